//--- common/id_pkg.sv
package id_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_SW      = 6'b101011;

    // function field of SPECIAL
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_JR   = 6'b001000;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_ADDU,
        ALU_SUB,
        ALU_SUBU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    // result offered back to decode by a later stage
    typedef struct packed {
        logic                  wreg;
        logic [REG_ADDR_W-1:0] wa;
        logic [DATA_W-1:0]     wd;
        logic                  mreg;
    } fwd_t;

    typedef struct packed {
        alu_op_e               alu_op;
        logic                  wreg;
        logic [REG_ADDR_W-1:0] wa;
        logic                  mreg;
        logic                  mwrite;
        logic                  rreg1;
        logic [REG_ADDR_W-1:0] ra1;
        logic                  rreg2;
        logic [REG_ADDR_W-1:0] ra2;
        logic                  shift;
        logic [REG_ADDR_W-1:0] sa;
        logic                  immsel;
        logic [DATA_W-1:0]     imm_ext;
        logic                  is_beq;
        logic                  is_bne;
        logic                  is_j;
        logic                  is_jr;
        logic [15:0]           imm16;
        logic [25:0]           instr_index;
    } ctrl_t;

    // bundle handed to execute
    typedef struct packed {
        alu_op_e               alu_op;
        logic [DATA_W-1:0]     src1;
        logic [DATA_W-1:0]     src2;
        logic [DATA_W-1:0]     din;
        logic [REG_ADDR_W-1:0] wa;
        logic                  wreg;
        logic                  mreg;
        logic                  mwrite;
    } id_ex_t;

    typedef struct packed {
        logic              taken;
        logic [DATA_W-1:0] target;
    } branch_t;

endpackage

//--- decoder/inst_decoder.sv
module inst_decoder (
    input  logic [id_pkg::DATA_W-1:0] inst_i,
    output id_pkg::ctrl_t             ctrl_o
);

    logic [5:0]                    op;
    logic [5:0]                    fn;
    logic [id_pkg::REG_ADDR_W-1:0] rs;
    logic [id_pkg::REG_ADDR_W-1:0] rt;
    logic [id_pkg::REG_ADDR_W-1:0] rd;
    logic [id_pkg::REG_ADDR_W-1:0] sa;
    logic [15:0]                   imm;
    logic [id_pkg::DATA_W-1:0]     imm_sext;
    logic [id_pkg::DATA_W-1:0]     imm_zext;
    logic                          known;
    logic                          imm_alu;

    // instruction fields
    assign op  = inst_i[31:26];
    assign rs  = inst_i[25:21];
    assign rt  = inst_i[20:16];
    assign rd  = inst_i[15:11];
    assign sa  = inst_i[10:6];
    assign fn  = inst_i[5:0];
    assign imm = inst_i[15:0];

    assign imm_sext = {{16{imm[15]}}, imm};
    assign imm_zext = {16'b0, imm};

    always_comb begin
        ctrl_o  = '0;
        known   = 1'b1;
        imm_alu = 1'b0;
        case (op)
            id_pkg::OP_SPECIAL: begin
                // register form, rd <- rs op rt
                ctrl_o.wreg  = 1'b1;
                ctrl_o.wa    = rd;
                ctrl_o.rreg1 = 1'b1;
                ctrl_o.rreg2 = 1'b1;
                case (fn)
                    id_pkg::FN_ADD:  ctrl_o.alu_op = id_pkg::ALU_ADD;
                    id_pkg::FN_ADDU: ctrl_o.alu_op = id_pkg::ALU_ADDU;
                    id_pkg::FN_SUB:  ctrl_o.alu_op = id_pkg::ALU_SUB;
                    id_pkg::FN_SUBU: ctrl_o.alu_op = id_pkg::ALU_SUBU;
                    id_pkg::FN_AND:  ctrl_o.alu_op = id_pkg::ALU_AND;
                    id_pkg::FN_OR:   ctrl_o.alu_op = id_pkg::ALU_OR;
                    id_pkg::FN_XOR:  ctrl_o.alu_op = id_pkg::ALU_XOR;
                    id_pkg::FN_NOR:  ctrl_o.alu_op = id_pkg::ALU_NOR;
                    id_pkg::FN_SLT:  ctrl_o.alu_op = id_pkg::ALU_SLT;
                    id_pkg::FN_SLTU: ctrl_o.alu_op = id_pkg::ALU_SLTU;
                    id_pkg::FN_SLL:  ctrl_o.alu_op = id_pkg::ALU_SLL;
                    id_pkg::FN_SRL:  ctrl_o.alu_op = id_pkg::ALU_SRL;
                    id_pkg::FN_SRA:  ctrl_o.alu_op = id_pkg::ALU_SRA;
                    id_pkg::FN_JR: begin
                        ctrl_o.wreg  = 1'b0;
                        ctrl_o.wa    = '0;
                        ctrl_o.rreg2 = 1'b0;
                        ctrl_o.is_jr = 1'b1;
                    end
                    default: known = 1'b0;
                endcase
                // shifts take sa in place of rs
                if (fn == id_pkg::FN_SLL || fn == id_pkg::FN_SRL || fn == id_pkg::FN_SRA) begin
                    ctrl_o.rreg1 = 1'b0;
                    ctrl_o.shift = 1'b1;
                    ctrl_o.sa    = sa;
                end
            end
            id_pkg::OP_ADDI: begin
                ctrl_o.alu_op  = id_pkg::ALU_ADD;
                ctrl_o.imm_ext = imm_sext;
                imm_alu        = 1'b1;
            end
            id_pkg::OP_ADDIU: begin
                ctrl_o.alu_op  = id_pkg::ALU_ADDU;
                ctrl_o.imm_ext = imm_sext;
                imm_alu        = 1'b1;
            end
            id_pkg::OP_SLTI: begin
                ctrl_o.alu_op  = id_pkg::ALU_SLT;
                ctrl_o.imm_ext = imm_sext;
                imm_alu        = 1'b1;
            end
            id_pkg::OP_SLTIU: begin
                ctrl_o.alu_op  = id_pkg::ALU_SLTU;
                ctrl_o.imm_ext = imm_sext;
                imm_alu        = 1'b1;
            end
            id_pkg::OP_ANDI: begin
                ctrl_o.alu_op  = id_pkg::ALU_AND;
                ctrl_o.imm_ext = imm_zext;
                imm_alu        = 1'b1;
            end
            id_pkg::OP_ORI: begin
                ctrl_o.alu_op  = id_pkg::ALU_OR;
                ctrl_o.imm_ext = imm_zext;
                imm_alu        = 1'b1;
            end
            id_pkg::OP_XORI: begin
                ctrl_o.alu_op  = id_pkg::ALU_XOR;
                ctrl_o.imm_ext = imm_zext;
                imm_alu        = 1'b1;
            end
            id_pkg::OP_LUI: begin
                // or with a zero first operand
                ctrl_o.alu_op  = id_pkg::ALU_OR;
                ctrl_o.wreg    = 1'b1;
                ctrl_o.wa      = rt;
                ctrl_o.immsel  = 1'b1;
                ctrl_o.imm_ext = {imm, 16'b0};
            end
            id_pkg::OP_LW: begin
                ctrl_o.alu_op  = id_pkg::ALU_ADDU;
                ctrl_o.imm_ext = imm_sext;
                ctrl_o.mreg    = 1'b1;
                imm_alu        = 1'b1;
            end
            id_pkg::OP_SW: begin
                ctrl_o.alu_op  = id_pkg::ALU_ADDU;
                ctrl_o.rreg1   = 1'b1;
                ctrl_o.rreg2   = 1'b1;
                ctrl_o.immsel  = 1'b1;
                ctrl_o.imm_ext = imm_sext;
                ctrl_o.mwrite  = 1'b1;
            end
            id_pkg::OP_BEQ: begin
                ctrl_o.rreg1  = 1'b1;
                ctrl_o.rreg2  = 1'b1;
                ctrl_o.is_beq = 1'b1;
            end
            id_pkg::OP_BNE: begin
                ctrl_o.rreg1  = 1'b1;
                ctrl_o.rreg2  = 1'b1;
                ctrl_o.is_bne = 1'b1;
            end
            id_pkg::OP_J: ctrl_o.is_j = 1'b1;
            default: known = 1'b0;
        endcase

        // rt <- rs op imm
        if (imm_alu) begin
            ctrl_o.wreg   = 1'b1;
            ctrl_o.wa     = rt;
            ctrl_o.rreg1  = 1'b1;
            ctrl_o.immsel = 1'b1;
        end

        if (known) begin
            ctrl_o.ra1         = rs;
            ctrl_o.ra2         = rt;
            ctrl_o.imm16       = imm;
            ctrl_o.instr_index = inst_i[25:0];
        end else begin
            // anything else becomes a bubble
            ctrl_o = '0;
        end
    end

endmodule

//--- logic/operand_forward.sv
module operand_forward (
    input  id_pkg::ctrl_t             ctrl_i,
    input  logic                      valid_i,
    input  logic [id_pkg::DATA_W-1:0] rf_rd1_i,
    input  logic [id_pkg::DATA_W-1:0] rf_rd2_i,
    input  id_pkg::fwd_t              exe_fwd_i,
    input  id_pkg::fwd_t              mem_fwd_i,
    output logic [id_pkg::DATA_W-1:0] src1_o,
    output logic [id_pkg::DATA_W-1:0] src2_o,
    output logic [id_pkg::DATA_W-1:0] din_o,
    output logic                      stall_o
);

    logic [id_pkg::DATA_W-1:0] op1;
    logic [id_pkg::DATA_W-1:0] op2;
    logic                      exe_hit;
    logic                      mem_hit;

    // read port matches a pending write
    function automatic logic fwd_hit(
        input logic                          rreg,
        input logic [id_pkg::REG_ADDR_W-1:0] ra,
        input id_pkg::fwd_t                  src
    );
        return rreg && src.wreg && (src.wa == ra);
    endfunction

    // execute beats memory beats register file
    function automatic logic [id_pkg::DATA_W-1:0] fwd_pick(
        input logic                          rreg,
        input logic [id_pkg::REG_ADDR_W-1:0] ra,
        input logic [id_pkg::DATA_W-1:0]     rf_rd,
        input id_pkg::fwd_t                  exe,
        input id_pkg::fwd_t                  mem
    );
        if (!rreg) begin
            return '0;
        end else if (fwd_hit(rreg, ra, exe)) begin
            return exe.wd;
        end else if (fwd_hit(rreg, ra, mem)) begin
            return mem.wd;
        end
        return rf_rd;
    endfunction

    assign op1 = fwd_pick(ctrl_i.rreg1, ctrl_i.ra1, rf_rd1_i, exe_fwd_i, mem_fwd_i);
    assign op2 = fwd_pick(ctrl_i.rreg2, ctrl_i.ra2, rf_rd2_i, exe_fwd_i, mem_fwd_i);

    assign src1_o = ctrl_i.shift ? {{(id_pkg::DATA_W - id_pkg::REG_ADDR_W){1'b0}}, ctrl_i.sa}
                                 : op1;
    assign src2_o = ctrl_i.immsel ? ctrl_i.imm_ext : op2;
    // store data always from rt
    assign din_o  = op2;

    // load data not ready yet, fetch must hold
    assign exe_hit = fwd_hit(ctrl_i.rreg1, ctrl_i.ra1, exe_fwd_i)
                   || fwd_hit(ctrl_i.rreg2, ctrl_i.ra2, exe_fwd_i);
    assign mem_hit = fwd_hit(ctrl_i.rreg1, ctrl_i.ra1, mem_fwd_i)
                   || fwd_hit(ctrl_i.rreg2, ctrl_i.ra2, mem_fwd_i);

    assign stall_o = valid_i && ((exe_hit && exe_fwd_i.mreg) || (mem_hit && mem_fwd_i.mreg));

endmodule

//--- logic/branch_resolve.sv
module branch_resolve (
    input  id_pkg::ctrl_t             ctrl_i,
    input  logic [id_pkg::DATA_W-1:0] pc_i,
    input  logic [id_pkg::DATA_W-1:0] src1_i,
    input  logic [id_pkg::DATA_W-1:0] src2_i,
    input  logic                      fire_i,
    output id_pkg::branch_t           branch_o
);

    logic [id_pkg::DATA_W-1:0] pc_plus4;
    logic [id_pkg::DATA_W-1:0] br_off;
    logic                      equal;
    logic                      cond;

    assign pc_plus4 = pc_i + 32'd4;
    // word offset, sign extended
    assign br_off   = {{14{ctrl_i.imm16[15]}}, ctrl_i.imm16, 2'b00};
    assign equal    = (src1_i == src2_i);

    assign cond = (ctrl_i.is_beq && equal)
               || (ctrl_i.is_bne && !equal)
               || ctrl_i.is_j
               || ctrl_i.is_jr;

    assign branch_o.taken = fire_i && cond;

    always_comb begin
        if (ctrl_i.is_j) begin
            // stays inside the current 256 MB region
            branch_o.target = {pc_plus4[31:28], ctrl_i.instr_index, 2'b00};
        end else if (ctrl_i.is_jr) begin
            branch_o.target = src1_i;
        end else if (ctrl_i.is_beq || ctrl_i.is_bne) begin
            branch_o.target = pc_plus4 + br_off;
        end else begin
            branch_o.target = '0;
        end
    end

endmodule

//--- logic/id_ex_reg.sv
module id_ex_reg (
    input  logic           cpu_clk_i,
    input  logic           rst_n_i,
    input  logic           load_i,
    input  id_pkg::id_ex_t d_i,
    output logic           valid_o,
    output id_pkg::id_ex_t q_o
);

    always_ff @(posedge cpu_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            // a stalled or idle cycle leaves a bubble
            valid_o <= load_i;
        end
    end

    always_ff @(posedge cpu_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            q_o <= '0;
        end else if (load_i) begin
            q_o <= d_i;
        end
    end

endmodule

//--- logic/id_stage.sv
module id_stage (
    input  logic                          cpu_clk_i,
    input  logic                          rst_n_i,
    input  logic                          inst_valid_i,
    input  logic [id_pkg::DATA_W-1:0]     inst_i,
    input  logic [id_pkg::DATA_W-1:0]     pc_i,
    input  logic [id_pkg::DATA_W-1:0]     rf_rd1_i,
    input  logic [id_pkg::DATA_W-1:0]     rf_rd2_i,
    input  id_pkg::fwd_t                  exe_fwd_i,
    input  id_pkg::fwd_t                  mem_fwd_i,
    output logic [id_pkg::REG_ADDR_W-1:0] rf_ra1_o,
    output logic [id_pkg::REG_ADDR_W-1:0] rf_ra2_o,
    output logic                          rf_re1_o,
    output logic                          rf_re2_o,
    output logic                          stall_o,
    output id_pkg::branch_t               branch_o,
    output logic                          exe_valid_o,
    output id_pkg::id_ex_t                exe_o
);

    id_pkg::ctrl_t             ctrl;
    id_pkg::id_ex_t            ex_d;
    logic [id_pkg::DATA_W-1:0] src1;
    logic [id_pkg::DATA_W-1:0] src2;
    logic [id_pkg::DATA_W-1:0] din;
    logic                      fire;

    inst_decoder u_decoder (
        .inst_i (inst_i),
        .ctrl_o (ctrl)
    );

    operand_forward u_forward (
        .ctrl_i    (ctrl),
        .valid_i   (inst_valid_i),
        .rf_rd1_i  (rf_rd1_i),
        .rf_rd2_i  (rf_rd2_i),
        .exe_fwd_i (exe_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .src1_o    (src1),
        .src2_o    (src2),
        .din_o     (din),
        .stall_o   (stall_o)
    );

    // instruction accepted this cycle
    assign fire = inst_valid_i && !stall_o;

    branch_resolve u_branch (
        .ctrl_i   (ctrl),
        .pc_i     (pc_i),
        .src1_i   (src1),
        .src2_i   (src2),
        .fire_i   (fire),
        .branch_o (branch_o)
    );

    assign rf_ra1_o = ctrl.ra1;
    assign rf_ra2_o = ctrl.ra2;
    assign rf_re1_o = ctrl.rreg1;
    assign rf_re2_o = ctrl.rreg2;

    assign ex_d.alu_op = ctrl.alu_op;
    assign ex_d.src1   = src1;
    assign ex_d.src2   = src2;
    assign ex_d.din    = din;
    assign ex_d.wa     = ctrl.wa;
    assign ex_d.wreg   = ctrl.wreg;
    assign ex_d.mreg   = ctrl.mreg;
    assign ex_d.mwrite = ctrl.mwrite;

    id_ex_reg u_id_ex (
        .cpu_clk_i (cpu_clk_i),
        .rst_n_i   (rst_n_i),
        .load_i    (fire),
        .d_i       (ex_d),
        .valid_o   (exe_valid_o),
        .q_o       (exe_o)
    );

endmodule

//--- testbench/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // reset held for eight rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

//--- testbench/tb_id_stage.sv
module tb_id_stage;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_R        = 110;
    localparam int N_I        = 110;
    localparam int N_FWD      = 80;
    localparam int N_LD       = 50;
    localparam int N_BR       = 100;
    localparam int N_STROBES  = N_R + N_I + N_FWD + 2 * N_LD + N_BR;
    localparam int MAX_CYCLES = 6 * N_STROBES;

    logic                 cpu_clk;
    logic                 rst_n;
    logic                 inst_valid;
    logic [31:0]          inst;
    logic [31:0]          pc;
    logic [31:0]          rf_rd1;
    logic [31:0]          rf_rd2;
    id_pkg::fwd_t         exe_fwd;
    id_pkg::fwd_t         mem_fwd;
    logic [4:0]           rf_ra1;
    logic [4:0]           rf_ra2;
    logic                 rf_re1;
    logic                 rf_re2;
    logic                 stall;
    id_pkg::branch_t      branch;
    logic                 exe_valid;
    id_pkg::id_ex_t       exe;

    int                   seed = 32'h13e2_f892;
    int                   errors = 0;
    int                   checks = 0;
    int                   cycles = 0;
    id_pkg::id_ex_t       exp_q[$];
    id_pkg::id_ex_t       exp_ex;
    id_pkg::id_ex_t       exp_prev;
    id_pkg::branch_t      exp_br;
    logic                 exp_stall;
    logic                 exp_re1;
    logic                 exp_re2;

    tb_clock_gen u_clk (
        .clk_o   (cpu_clk),
        .rst_n_o (rst_n)
    );

    id_stage dut0 (
        .cpu_clk_i    (cpu_clk),
        .rst_n_i      (rst_n),
        .inst_valid_i (inst_valid),
        .inst_i       (inst),
        .pc_i         (pc),
        .rf_rd1_i     (rf_rd1),
        .rf_rd2_i     (rf_rd2),
        .exe_fwd_i    (exe_fwd),
        .mem_fwd_i    (mem_fwd),
        .rf_ra1_o     (rf_ra1),
        .rf_ra2_o     (rf_ra2),
        .rf_re1_o     (rf_re1),
        .rf_re2_o     (rf_re2),
        .stall_o      (stall),
        .branch_o     (branch),
        .exe_valid_o  (exe_valid),
        .exe_o        (exe)
    );

    // register file model holding its index in every byte
    function automatic logic [31:0] rf_value(input logic [4:0] r);
        return {27'b0, r} * 32'h0101_0101;
    endfunction

    assign rf_rd1 = rf_value(rf_ra1);
    assign rf_rd2 = rf_value(rf_ra2);

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [31:0] r;
        r = $random(seed);
        return 5'(r % 32'd31) + 5'd1;
    endfunction

    function automatic id_pkg::fwd_t make_fwd(input logic wreg, input logic [4:0] wa,
                                              input logic [31:0] wd, input logic mreg);
        id_pkg::fwd_t f;
        f.wreg = wreg;
        f.wa   = wa;
        f.wd   = wd;
        f.mreg = mreg;
        return f;
    endfunction

    function automatic logic [31:0] rtype(input logic [5:0] fn, input logic [4:0] rs, rt, rd, sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs, rt,
                                          input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // the thirteen ALU and shift function codes
    function automatic logic [5:0] pick_fn(input int k);
        case (k)
            0: return 6'h20;
            1: return 6'h21;
            2: return 6'h22;
            3: return 6'h23;
            4: return 6'h24;
            5: return 6'h25;
            6: return 6'h26;
            7: return 6'h27;
            8: return 6'h2a;
            9: return 6'h2b;
            10: return 6'h00;
            11: return 6'h02;
            default: return 6'h03;
        endcase
    endfunction

    // immediate forms, lui, lw and sw
    function automatic logic [5:0] pick_op(input int k);
        case (k)
            0: return 6'h08;
            1: return 6'h09;
            2: return 6'h0a;
            3: return 6'h0b;
            4: return 6'h0c;
            5: return 6'h0d;
            6: return 6'h0e;
            7: return 6'h0f;
            8: return 6'h23;
            default: return 6'h2b;
        endcase
    endfunction

    // regimm, jal, blez, bgtz, cop0, lb, sb
    function automatic logic [5:0] pick_bad_op(input int k);
        case (k)
            0: return 6'h01;
            1: return 6'h03;
            2: return 6'h06;
            3: return 6'h07;
            4: return 6'h10;
            5: return 6'h20;
            default: return 6'h28;
        endcase
    endfunction

    function automatic id_pkg::alu_op_e rtype_alu(input logic [5:0] fn);
        case (fn)
            6'h20: return id_pkg::ALU_ADD;
            6'h21: return id_pkg::ALU_ADDU;
            6'h22: return id_pkg::ALU_SUB;
            6'h23: return id_pkg::ALU_SUBU;
            6'h24: return id_pkg::ALU_AND;
            6'h25: return id_pkg::ALU_OR;
            6'h26: return id_pkg::ALU_XOR;
            6'h27: return id_pkg::ALU_NOR;
            6'h2a: return id_pkg::ALU_SLT;
            6'h2b: return id_pkg::ALU_SLTU;
            6'h00: return id_pkg::ALU_SLL;
            6'h02: return id_pkg::ALU_SRL;
            6'h03: return id_pkg::ALU_SRA;
            default: return id_pkg::ALU_NOP;
        endcase
    endfunction

    // rt <- rs op imm forms and the lw address add
    function automatic id_pkg::alu_op_e itype_alu(input logic [5:0] op);
        case (op)
            6'h08: return id_pkg::ALU_ADD;
            6'h09: return id_pkg::ALU_ADDU;
            6'h0a: return id_pkg::ALU_SLT;
            6'h0b: return id_pkg::ALU_SLTU;
            6'h0c: return id_pkg::ALU_AND;
            6'h0d: return id_pkg::ALU_OR;
            6'h0e: return id_pkg::ALU_XOR;
            6'h23: return id_pkg::ALU_ADDU;
            default: return id_pkg::ALU_NOP;
        endcase
    endfunction

    // execute before memory before register file
    function automatic logic [31:0] fwd_value(input logic [4:0] r, input id_pkg::fwd_t ex_s,
                                              input id_pkg::fwd_t mem_s);
        if (ex_s.wreg && ex_s.wa == r) begin
            return ex_s.wd;
        end else if (mem_s.wreg && mem_s.wa == r) begin
            return mem_s.wd;
        end
        return rf_value(r);
    endfunction

    function automatic logic load_hit(input logic [4:0] r, input id_pkg::fwd_t ex_s,
                                      input id_pkg::fwd_t mem_s);
        return (ex_s.wreg && ex_s.mreg && ex_s.wa == r)
            || (mem_s.wreg && mem_s.mreg && mem_s.wa == r);
    endfunction

    // expected decode result for one instruction word
    function automatic void predict(
        input  logic [31:0]     word,
        input  logic [31:0]     pc_v,
        input  logic            strobe,
        input  id_pkg::fwd_t    ex_s,
        input  id_pkg::fwd_t    mem_s,
        output id_pkg::id_ex_t  ex,
        output logic            stall_e,
        output id_pkg::branch_t br,
        output logic            re1,
        output logic            re2
    );
        logic [5:0]      op;
        logic [5:0]      fn;
        logic [4:0]      rs;
        logic [4:0]      rt;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     sx;
        logic [31:0]     pc4;
        logic            cond;
        id_pkg::alu_op_e r_op;
        id_pkg::alu_op_e i_op;
        op = word[31:26];
        fn = word[5:0];
        rs = word[25:21];
        rt = word[20:16];
        a = fwd_value(rs, ex_s, mem_s);
        b = fwd_value(rt, ex_s, mem_s);
        sx = {{16{word[15]}}, word[15:0]};
        pc4 = pc_v + 32'd4;
        r_op = rtype_alu(fn);
        i_op = itype_alu(op);
        ex = '0;
        br = '0;
        re1 = 1'b0;
        re2 = 1'b0;
        cond = 1'b0;
        if (op == 6'h00 && r_op != id_pkg::ALU_NOP) begin
            // shifts read only rt and take sa as operand 1
            re1 = !(fn inside {6'h00, 6'h02, 6'h03});
            re2 = 1'b1;
            ex.alu_op = r_op;
            ex.wreg = 1'b1;
            ex.wa = word[15:11];
            ex.src1 = re1 ? a : {27'b0, word[10:6]};
            ex.src2 = b;
            ex.din = b;
        end else if (op == 6'h00 && fn == 6'h08) begin
            re1 = 1'b1;
            ex.src1 = a;
            cond = 1'b1;
            br.target = a;
        end else if (i_op != id_pkg::ALU_NOP) begin
            re1 = 1'b1;
            ex.alu_op = i_op;
            ex.wreg = 1'b1;
            ex.wa = rt;
            ex.mreg = (op == 6'h23);
            ex.src1 = a;
            ex.src2 = (op inside {6'h0c, 6'h0d, 6'h0e}) ? {16'h0, word[15:0]} : sx;
        end else if (op == 6'h0f) begin
            ex.alu_op = id_pkg::ALU_OR;
            ex.wreg = 1'b1;
            ex.wa = rt;
            ex.src2 = {word[15:0], 16'h0};
        end else if (op == 6'h2b) begin
            re1 = 1'b1;
            re2 = 1'b1;
            ex.alu_op = id_pkg::ALU_ADDU;
            ex.mwrite = 1'b1;
            ex.src1 = a;
            ex.src2 = sx;
            ex.din = b;
        end else if (op == 6'h04 || op == 6'h05) begin
            re1 = 1'b1;
            re2 = 1'b1;
            ex.src1 = a;
            ex.src2 = b;
            ex.din = b;
            cond = (op == 6'h04) ? (a == b) : (a != b);
            br.target = pc4 + (sx << 2);
        end else if (op == 6'h02) begin
            cond = 1'b1;
            br.target = {pc4[31:28], word[25:0], 2'b00};
        end
        stall_e = strobe && ((re1 && load_hit(rs, ex_s, mem_s))
                          || (re2 && load_hit(rt, ex_s, mem_s)));
        br.taken = strobe && !stall_e && cond;
    endfunction

    task automatic check(input string name, input logic [127:0] expected,
                         input logic [127:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %0t %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic issue(input logic [31:0] word, input id_pkg::fwd_t ex_s,
                         input id_pkg::fwd_t mem_s);
        logic [31:0] r;
        @(posedge cpu_clk);
        r = rand_word();
        #1;
        inst_valid = 1'b1;
        inst = word;
        pc = {r[31:2], 2'b00};
        exe_fwd = ex_s;
        mem_fwd = mem_s;
    endtask

    task automatic idle();
        @(posedge cpu_clk);
        #1;
        inst_valid = 1'b0;
        exe_fwd = '0;
        mem_fwd = '0;
    endtask

    // outputs are stable at the falling edge
    always @(negedge cpu_clk) begin
        if (rst_n) begin
            predict(inst, pc, inst_valid, exe_fwd, mem_fwd,
                    exp_ex, exp_stall, exp_br, exp_re1, exp_re2);
            if (exp_q.size() > 0) begin
                exp_prev = exp_q.pop_front();
                check("exe_valid_o", 128'(1'b1), 128'(exe_valid));
                check("exe_o", 128'(exp_prev), 128'(exe));
            end else begin
                check("exe_valid_o", 128'(1'b0), 128'(exe_valid));
            end
            check("stall_o", 128'(exp_stall), 128'(stall));
            if (inst_valid) begin
                check("branch_o", 128'(exp_br), 128'(branch));
                check("rf_re1_o", 128'(exp_re1), 128'(rf_re1));
                check("rf_re2_o", 128'(exp_re2), 128'(rf_re2));
                if (exp_re1) begin
                    check("rf_ra1_o", 128'(inst[25:21]), 128'(rf_ra1));
                end
                if (exp_re2) begin
                    check("rf_ra2_o", 128'(inst[20:16]), 128'(rf_ra2));
                end
                if (!exp_stall) begin
                    exp_q.push_back(exp_ex);
                end
            end else begin
                check("branch_o.taken", 128'(1'b0), 128'(branch.taken));
            end
        end
    end

    always @(posedge cpu_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the test did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        int          i;
        logic [4:0]  a;
        logic [4:0]  b;
        logic [31:0] r;
        logic [31:0] w;
        inst_valid = 1'b0;
        inst = '0;
        pc = '0;
        exe_fwd = '0;
        mem_fwd = '0;
        @(posedge rst_n);
        repeat (3) idle();

        // register forms with both bypass sources idle
        for (i = 0; i < N_R; i++) begin
            r = rand_word();
            issue(rtype(pick_fn(i % 13), rand_reg(), rand_reg(), rand_reg(), r[10:6]), '0, '0);
            if (r[3:0] == 4'h0) begin
                idle();
            end
        end

        for (i = 0; i < N_I; i++) begin
            r = rand_word();
            issue(itype(pick_op(i % 10), rand_reg(), rand_reg(), r[31:16]), '0, '0);
            if (r[3:0] == 4'h0) begin
                idle();
            end
        end

        // priority between execute, memory and register file
        for (i = 0; i < N_FWD; i++) begin
            a = rand_reg();
            b = rand_reg();
            r = rand_word();
            w = (i % 8 < 4) ? rtype(6'h21, a, b, rand_reg(), 5'd0) : itype(6'h2b, a, b, r[15:0]);
            case (i % 4)
                0: issue(w, make_fwd(1'b1, a, rand_word(), 1'b0),
                         make_fwd(1'b1, a, rand_word(), 1'b0));
                1: issue(w, make_fwd(1'b0, b, rand_word(), 1'b0),
                         make_fwd(1'b1, b, rand_word(), 1'b0));
                2: issue(w, make_fwd(1'b1, 5'd0, rand_word(), 1'b0),
                         make_fwd(1'b0, a, rand_word(), 1'b0));
                default: issue(w, make_fwd(1'b1, b, rand_word(), 1'b0),
                               make_fwd(1'b1, a, rand_word(), 1'b0));
            endcase
        end

        // load-use case followed by the same word again
        for (i = 0; i < N_LD; i++) begin
            a = rand_reg();
            b = rand_reg();
            r = rand_word();
            w = (i % 2 == 0) ? rtype(6'h2a, a, b, rand_reg(), 5'd0) : itype(6'h04, a, b, r[15:0]);
            case (i % 4)
                0: issue(w, make_fwd(1'b1, a, rand_word(), 1'b1), '0);
                1: issue(w, '0, make_fwd(1'b1, b, rand_word(), 1'b1));
                2: issue(w, make_fwd(1'b1, 5'd0, rand_word(), 1'b1), '0);
                default: issue(w, make_fwd(1'b1, a, rand_word(), 1'b0),
                               make_fwd(1'b1, b, r, 1'b0));
            endcase
            issue(w, '0, '0);
        end

        for (i = 0; i < N_BR; i++) begin
            a = rand_reg();
            r = rand_word();
            b = r[4] ? a : rand_reg();
            case (i % 5)
                0, 1: begin
                    w = itype((i % 5 == 0) ? 6'h04 : 6'h05, a, b, r[31:16]);
                    // bypassed rs made equal to rt
                    if (r[5]) begin
                        issue(w, make_fwd(1'b1, a, rf_value(b), 1'b0), '0);
                    end else begin
                        issue(w, '0, '0);
                    end
                end
                2: issue({6'h02, r[25:0]}, '0, '0);
                // rt and rd fields filled so that jr must ignore them
                3: issue(rtype(6'h08, a, b, rand_reg(), 5'd0),
                         make_fwd(r[6], a, rand_word(), 1'b0), '0);
                default: begin
                    if (r[7]) begin
                        issue(rtype(6'h18, a, b, 5'd0, 5'd0), '0, '0);
                    end else begin
                        issue({pick_bad_op(i % 7), r[25:0]}, '0, '0);
                    end
                end
            endcase
        end

        idle();
        idle();
        @(negedge cpu_clk);
        #1;
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- id_stage.f
common/id_pkg.sv
decoder/inst_decoder.sv
logic/operand_forward.sv
logic/branch_resolve.sv
logic/id_ex_reg.sv
logic/id_stage.sv
testbench/tb_clock_gen.sv
testbench/tb_id_stage.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then scan the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps -f id_stage.f \
    --top-module tb_id_stage -Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/Vtb_id_stage > sim.log 2>&1 \
    || { echo "build or run error, see build.log and sim.log"; exit 1; }
grep -q "Simulation failed" sim.log \
    && { echo "test FAILED, see sim.log"; exit 1; } \
    || echo "test PASSED"
exit 0
